// File: fir_mac.f
src/fir_pkg.sv
src/fir_reg_decode.sv
src/fir_mac_engine.sv
src/fir_out_stage.sv
src/fir_top.sv
tests/tb_fir_top.sv

// File: run.sh
#!/bin/sh
# compile the fir_mac testbench with verilator and run it
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_fir_top \
    -f fir_mac.f \
    -o sim_fir

out=$(./obj_dir/sim_fir)
echo "$out"

# pass only if the testbench printed its pass line
if echo "$out" | grep -q "All tests passed"; then
    exit 0
else
    exit 1
fi

// File: tests/tb_fir_top.sv
`timescale 1ns/10ps

module tb_fir_top;

    import fir_pkg::*;

    localparam int NUM_TAPS   = 11;
    localparam int ADDR_W     = 12;
    localparam int RST_CYCLES = 8;
    // three frames of at most 24 samples
    localparam int NUM_FRAMES = 3;
    localparam int MAX_LEN    = 24;
    localparam int REG_ACC    = 2 * NUM_TAPS + 10;
    localparam int LIMIT      = 4 * NUM_FRAMES * MAX_LEN * (NUM_TAPS + 1) + 20 * REG_ACC
                                + RST_CYCLES;

    logic              axis_clk;
    logic              axis_rst_n;
    logic              awvalid;
    logic [ADDR_W-1:0] awaddr;
    logic              awready;
    logic              wvalid;
    logic [WORD_W-1:0] wdata;
    logic              wready;
    logic              arvalid;
    logic [ADDR_W-1:0] araddr;
    logic              arready;
    logic              rvalid;
    logic              rready;
    logic [WORD_W-1:0] rdata;
    logic              ss_tvalid;
    logic [WORD_W-1:0] ss_tdata;
    logic              ss_tlast;
    logic              ss_tready;
    logic              sm_tvalid;
    logic [WORD_W-1:0] sm_tdata;
    logic              sm_tlast;
    logic              sm_tready;

    // model state
    logic [15:0]       lfsr_q;
    logic [WORD_W-1:0] tap_m [NUM_TAPS];
    logic [WORD_W-1:0] samp_m [MAX_LEN];
    logic [WORD_W-1:0] exp_m [MAX_LEN];
    int                gap_m [MAX_LEN];
    logic              ready_m [64];
    int                err_cnt;
    int                errs_before;
    int                tests_run;
    int                tests_ok;
    int                cycle_cnt;

    fir_top #(
        .NUM_TAPS (NUM_TAPS),
        .ADDR_W   (ADDR_W)
    ) i_dut (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .awvalid    (awvalid),
        .awaddr     (awaddr),
        .awready    (awready),
        .wvalid     (wvalid),
        .wdata      (wdata),
        .wready     (wready),
        .arvalid    (arvalid),
        .araddr     (araddr),
        .arready    (arready),
        .rvalid     (rvalid),
        .rready     (rready),
        .rdata      (rdata),
        .ss_tvalid  (ss_tvalid),
        .ss_tdata   (ss_tdata),
        .ss_tlast   (ss_tlast),
        .ss_tready  (ss_tready),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast),
        .sm_tready  (sm_tready)
    );

    // 8 ns period
    always #4 axis_clk = ~axis_clk;

    // watchdog
    always @(posedge axis_clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= LIMIT) begin
            $display("simulation timed out after %0d cycles, DUT stopped responding",
                     cycle_cnt);
            $display("Some tests failed");
            $finish;
        end
    end

    // fibonacci lfsr x^16+x^14+x^13+x^11, one step per bit
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        logic        fb;
        v = '0;
        for (int i = 0; i < n; i++) begin
            fb     = lfsr_q[15] ^ lfsr_q[13] ^ lfsr_q[12] ^ lfsr_q[10];
            lfsr_q = {lfsr_q[14:0], fb};
            v      = {v[30:0], fb};
        end
        return v;
    endfunction

    task automatic check_val(input string name, input logic [31:0] exp,
                             input logic [31:0] got);
        assert (got === exp) else begin
            $display("CHECK FAILED t=%0t %s expected 0x%h actual 0x%h",
                     $time, name, exp, got);
            err_cnt++;
        end
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (err_cnt == errs_before) begin
            tests_ok++;
            $display("test %0d %s: ok", tests_run, name);
        end else begin
            $display("test %0d %s: %0d errors", tests_run, name, err_cnt - errs_before);
        end
        errs_before = err_cnt;
    endtask

    // all bus tasks start and end 1 ns after a rising edge
    task automatic write_reg(input int addr, input logic [31:0] data);
        awaddr  = ADDR_W'(addr);
        wdata   = data;
        awvalid = 1'b1;
        wvalid  = 1'b1;
        @(negedge axis_clk);
        while (!awready) @(negedge axis_clk);
        @(posedge axis_clk);
        #1;
        awvalid = 1'b0;
        wvalid  = 1'b0;
    endtask

    task automatic read_reg(input int addr, output logic [31:0] data);
        araddr  = ADDR_W'(addr);
        arvalid = 1'b1;
        rready  = 1'b1;
        @(negedge axis_clk);
        while (!arready) @(negedge axis_clk);
        @(posedge axis_clk);
        #1;
        arvalid = 1'b0;
        // rdata stable once rvalid is up
        @(negedge axis_clk);
        while (!rvalid) @(negedge axis_clk);
        data = rdata;
        @(posedge axis_clk);
        #1;
        rready = 1'b0;
    endtask

    task automatic send_frame(input int n);
        for (int i = 0; i < n; i++) begin
            ss_tvalid = 1'b0;
            repeat (gap_m[i]) begin
                @(posedge axis_clk);
                #1;
            end
            ss_tvalid = 1'b1;
            ss_tdata  = samp_m[i];
            ss_tlast  = (i == n - 1);
            @(negedge axis_clk);
            while (!ss_tready) @(negedge axis_clk);
            @(posedge axis_clk);
            #1;
        end
        ss_tvalid = 1'b0;
        ss_tlast  = 1'b0;
    endtask

    task automatic collect_frame(input int n);
        int idx;
        int cyc;
        idx = 0;
        cyc = 0;
        while (idx < n) begin
            // random stalls on the output side
            sm_tready = ready_m[cyc % 64];
            cyc++;
            @(negedge axis_clk);
            if (sm_tvalid && sm_tready) begin
                check_val($sformatf("sm_tdata[%0d]", idx), exp_m[idx], sm_tdata);
                check_val("sm_tlast", 32'(idx == n - 1), 32'(sm_tlast));
                idx++;
            end
            @(posedge axis_clk);
            #1;
        end
        sm_tready = 1'b0;
    endtask

    // random frame, model outputs from the current taps, then stream it
    task automatic run_frame();
        int          n;
        logic [31:0] acc;
        n = 12 + int'(rand_bits(5) % 13);
        for (int i = 0; i < n; i++) begin
            samp_m[i] = rand_bits(32);
            gap_m[i]  = int'(rand_bits(2));
        end
        for (int i = 0; i < 64; i++) begin
            ready_m[i] = (rand_bits(2) != 0);
        end
        // samples before the frame count as zero
        for (int i = 0; i < n; i++) begin
            acc = '0;
            for (int k = 0; k < NUM_TAPS; k++) begin
                if (i - k >= 0) begin
                    acc = acc + tap_m[k] * samp_m[i - k];
                end
            end
            exp_m[i] = acc;
        end
        fork
            send_frame(n);
            collect_frame(n);
        join
    endtask

    initial begin
        logic [31:0] rd;
        lfsr_q      = 16'd16;
        axis_clk    = 1'b0;
        axis_rst_n  = 1'b0;
        awvalid     = 1'b0;
        awaddr      = '0;
        wvalid      = 1'b0;
        wdata       = '0;
        arvalid     = 1'b0;
        araddr      = '0;
        rready      = 1'b0;
        ss_tvalid   = 1'b0;
        ss_tdata    = '0;
        ss_tlast    = 1'b0;
        sm_tready   = 1'b0;
        err_cnt     = 0;
        errs_before = 0;
        tests_run   = 0;
        tests_ok    = 0;
        cycle_cnt   = 0;
        repeat (RST_CYCLES) @(posedge axis_clk);
        #1;
        axis_rst_n = 1'b1;

        // reset state
        @(negedge axis_clk);
        check_val("awready", 32'h0, 32'(awready));
        check_val("wready", 32'h0, 32'(wready));
        check_val("arready", 32'h0, 32'(arready));
        check_val("rvalid", 32'h0, 32'(rvalid));
        check_val("ss_tready", 32'h0, 32'(ss_tready));
        check_val("sm_tvalid", 32'h0, 32'(sm_tvalid));
        check_val("sm_tlast", 32'h0, 32'(sm_tlast));
        @(posedge axis_clk);
        #1;
        read_reg(CTRL_ADDR, rd);
        check_val("ctrl", 32'h4, rd);
        finish_test("reset state");

        // coefficient write and readback
        for (int k = 0; k < NUM_TAPS; k++) begin
            tap_m[k] = rand_bits(32);
            write_reg(TAP_BASE_ADDR + 4 * k, tap_m[k]);
        end
        for (int k = 0; k < NUM_TAPS; k++) begin
            read_reg(TAP_BASE_ADDR + 4 * k, rd);
            check_val($sformatf("tap%0d", k), tap_m[k], rd);
        end
        // first word past the tap window
        read_reg(TAP_BASE_ADDR + 4 * NUM_TAPS, rd);
        check_val("unmapped", 32'h0, rd);
        finish_test("coefficient access");

        write_reg(CTRL_ADDR, 32'h1);
        run_frame();
        finish_test("filtering under back-pressure");

        // done read once, then cleared
        read_reg(CTRL_ADDR, rd);
        check_val("ctrl", 32'h6, rd);
        read_reg(CTRL_ADDR, rd);
        check_val("ctrl", 32'h4, rd);
        finish_test("completion status");

        // tap write while running is dropped
        write_reg(CTRL_ADDR, 32'h1);
        write_reg(TAP_BASE_ADDR, ~tap_m[0]);
        read_reg(TAP_BASE_ADDR, rd);
        check_val("tap0", tap_m[0], rd);
        run_frame();
        finish_test("tap lock while running");

        // new taps while idle, fresh history on the next start
        tap_m[3] = rand_bits(32);
        write_reg(TAP_BASE_ADDR + 12, tap_m[3]);
        write_reg(CTRL_ADDR, 32'h1);
        run_frame();
        finish_test("history clear");

        $display("%0d of %0d tests ok, %0d failed checks", tests_ok, tests_run, err_cnt);
        if (err_cnt == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: src/fir_top.sv
`timescale 1ns/10ps

module fir_top #(
    parameter int NUM_TAPS = 11,
    parameter int ADDR_W   = 12
) (
    input  logic                       axis_clk,
    input  logic                       axis_rst_n,
    // lite write
    input  logic                       awvalid,
    input  logic [ADDR_W-1:0]          awaddr,
    output logic                       awready,
    input  logic                       wvalid,
    input  logic [fir_pkg::WORD_W-1:0] wdata,
    output logic                       wready,
    // lite read
    input  logic                       arvalid,
    input  logic [ADDR_W-1:0]          araddr,
    output logic                       arready,
    output logic                       rvalid,
    input  logic                       rready,
    output logic [fir_pkg::WORD_W-1:0] rdata,
    // samples in
    input  logic                       ss_tvalid,
    input  logic [fir_pkg::WORD_W-1:0] ss_tdata,
    input  logic                       ss_tlast,
    output logic                       ss_tready,
    // results out
    output logic                       sm_tvalid,
    output logic [fir_pkg::WORD_W-1:0] sm_tdata,
    output logic                       sm_tlast,
    input  logic                       sm_tready
);

    import fir_pkg::*;

    logic [NUM_TAPS*WORD_W-1:0] taps;
    logic                       run;
    logic                       frame_start;
    logic                       ss_accept;
    logic                       last_done;
    // engine to output stage
    logic                       res_valid;
    logic [WORD_W-1:0]          res_data;
    logic                       res_last;
    logic                       res_ready;

    fir_reg_decode #(
        .NUM_TAPS (NUM_TAPS),
        .ADDR_W   (ADDR_W)
    ) i_reg_decode (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .awvalid     (awvalid),
        .awaddr      (awaddr),
        .wvalid      (wvalid),
        .wdata       (wdata),
        .awready     (awready),
        .wready      (wready),
        .arvalid     (arvalid),
        .araddr      (araddr),
        .rready      (rready),
        .arready     (arready),
        .rvalid      (rvalid),
        .rdata       (rdata),
        .ss_accept   (ss_accept),
        .last_done   (last_done),
        .taps        (taps),
        .run         (run),
        .frame_start (frame_start)
    );

    fir_mac_engine #(
        .NUM_TAPS (NUM_TAPS)
    ) i_mac_engine (
        .axis_clk    (axis_clk),
        .axis_rst_n  (axis_rst_n),
        .ss_tvalid   (ss_tvalid),
        .ss_tdata    (ss_tdata),
        .ss_tlast    (ss_tlast),
        .ss_tready   (ss_tready),
        .taps        (taps),
        .run         (run),
        .frame_start (frame_start),
        .ss_accept   (ss_accept),
        .res_valid   (res_valid),
        .res_data    (res_data),
        .res_last    (res_last),
        .res_ready   (res_ready)
    );

    fir_out_stage i_out_stage (
        .axis_clk   (axis_clk),
        .axis_rst_n (axis_rst_n),
        .res_valid  (res_valid),
        .res_data   (res_data),
        .res_last   (res_last),
        .res_ready  (res_ready),
        .sm_tvalid  (sm_tvalid),
        .sm_tdata   (sm_tdata),
        .sm_tlast   (sm_tlast),
        .sm_tready  (sm_tready),
        .last_done  (last_done)
    );

endmodule

// File: src/fir_out_stage.sv
`timescale 1ns/10ps

module fir_out_stage (
    input  logic                       axis_clk,
    input  logic                       axis_rst_n,
    // result from the mac engine
    input  logic                       res_valid,
    input  logic [fir_pkg::WORD_W-1:0] res_data,
    input  logic                       res_last,
    output logic                       res_ready,
    // result output stream
    output logic                       sm_tvalid,
    output logic [fir_pkg::WORD_W-1:0] sm_tdata,
    output logic                       sm_tlast,
    input  logic                       sm_tready,
    // frame end seen on the stream
    output logic                       last_done
);

    import fir_pkg::*;

    logic              full_q;
    logic              last_q;
    logic [WORD_W-1:0] data_q;
    logic              load;

    // empty, or draining this cycle
    assign res_ready = !full_q || sm_tready;
    assign load      = res_valid && res_ready;

    assign sm_tvalid = full_q;
    assign sm_tdata  = data_q;
    assign sm_tlast  = full_q && last_q;

    // pulse on the tlast transfer
    assign last_done = full_q && last_q && sm_tready;

    // occupancy and tlast flag
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            full_q <= 1'b0;
            last_q <= 1'b0;
        end else if (load) begin
            full_q <= 1'b1;
            last_q <= res_last;
        end else if (sm_tready) begin
            full_q <= 1'b0;
            last_q <= 1'b0;
        end
    end

    always_ff @(posedge axis_clk) begin
        if (load) begin
            data_q <= res_data;
        end
    end

endmodule

// File: src/fir_mac_engine.sv
`timescale 1ns/10ps

module fir_mac_engine #(
    parameter int NUM_TAPS = 11
) (
    input  logic                                axis_clk,
    input  logic                                axis_rst_n,
    // sample input stream
    input  logic                                ss_tvalid,
    input  logic [fir_pkg::WORD_W-1:0]          ss_tdata,
    input  logic                                ss_tlast,
    output logic                                ss_tready,
    // from the register block
    input  logic [NUM_TAPS*fir_pkg::WORD_W-1:0] taps,
    input  logic                                run,
    input  logic                                frame_start,
    output logic                                ss_accept,
    // finished result towards the output stage
    output logic                                res_valid,
    output logic [fir_pkg::WORD_W-1:0]          res_data,
    output logic                                res_last,
    input  logic                                res_ready
);

    import fir_pkg::*;

    localparam int IDX_W = (NUM_TAPS > 1) ? $clog2(NUM_TAPS) : 1;
    localparam logic [IDX_W-1:0] LAST_IDX = IDX_W'(NUM_TAPS - 1);

    // engine FSM encoding
    localparam logic [1:0] S_WAIT = 2'd0;
    localparam logic [1:0] S_CALC = 2'd1;
    localparam logic [1:0] S_HOLD = 2'd2;

    logic [1:0]               state_q;
    logic [IDX_W-1:0]         tap_cnt_q;
    logic [IDX_W-1:0]         wr_ptr_q;
    logic [IDX_W-1:0]         rd_ptr_q;
    logic                     last_q;
    logic signed [WORD_W-1:0] tap_arr [NUM_TAPS];
    logic signed [WORD_W-1:0] hist_q [NUM_TAPS];
    logic signed [WORD_W-1:0] coef_k;
    logic signed [WORD_W-1:0] samp_k;
    logic signed [WORD_W-1:0] prod;
    logic signed [WORD_W-1:0] psum_q;

    // unpack coefficient words
    for (genvar i = 0; i < NUM_TAPS; i++) begin : g_unpack
        assign tap_arr[i] = taps[i*WORD_W +: WORD_W];
    end

    // take a sample only between results and not while the history clears
    assign ss_tready = run && !frame_start && (state_q == S_WAIT);
    assign ss_accept = ss_tvalid && ss_tready;

    // tap k against the sample k steps back
    assign coef_k = tap_arr[tap_cnt_q];
    assign samp_k = hist_q[rd_ptr_q];
    // single multiplier keeps the low word
    assign prod   = coef_k * samp_k;

    assign res_valid = (state_q == S_HOLD);
    assign res_data  = psum_q;
    assign res_last  = last_q;

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state_q   <= S_WAIT;
            tap_cnt_q <= '0;
            wr_ptr_q  <= '0;
            rd_ptr_q  <= '0;
            last_q    <= 1'b0;
        end else begin
            // new frame writes from slot 0 again
            if (frame_start) begin
                wr_ptr_q <= '0;
            end
            case (state_q)
                S_WAIT: begin
                    if (ss_accept) begin
                        // newest sample is where reading starts
                        rd_ptr_q  <= wr_ptr_q;
                        wr_ptr_q  <= (wr_ptr_q == LAST_IDX) ? '0 : wr_ptr_q + 1'b1;
                        tap_cnt_q <= '0;
                        last_q    <= ss_tlast;
                        state_q   <= S_CALC;
                    end
                end
                S_CALC: begin
                    // walk back through history and wrap at slot 0
                    tap_cnt_q <= tap_cnt_q + 1'b1;
                    rd_ptr_q  <= (rd_ptr_q == '0) ? LAST_IDX : rd_ptr_q - 1'b1;
                    if (tap_cnt_q == LAST_IDX) begin
                        state_q <= S_HOLD;
                    end
                end
                S_HOLD: begin
                    // result sits here until the output stage takes it
                    if (res_ready) begin
                        state_q <= S_WAIT;
                    end
                end
                default: state_q <= S_WAIT;
            endcase
        end
    end

    // sample history and partial sum
    always_ff @(posedge axis_clk) begin
        if (frame_start) begin
            // older samples count as zero in a new frame
            for (int i = 0; i < NUM_TAPS; i++) begin
                hist_q[i] <= '0;
            end
        end else if (ss_accept) begin
            hist_q[wr_ptr_q] <= ss_tdata;
        end
        if (ss_accept) begin
            psum_q <= '0;
        end else if (state_q == S_CALC) begin
            // single adder into the partial sum
            psum_q <= psum_q + prod;
        end
    end

endmodule

// File: src/fir_reg_decode.sv
`timescale 1ns/10ps

module fir_reg_decode #(
    parameter int NUM_TAPS = 11,
    parameter int ADDR_W   = 12
) (
    input  logic                                axis_clk,
    input  logic                                axis_rst_n,
    // lite write address and data
    input  logic                                awvalid,
    input  logic [ADDR_W-1:0]                   awaddr,
    input  logic                                wvalid,
    input  logic [fir_pkg::WORD_W-1:0]          wdata,
    output logic                                awready,
    output logic                                wready,
    // lite read address and data
    input  logic                                arvalid,
    input  logic [ADDR_W-1:0]                   araddr,
    input  logic                                rready,
    output logic                                arready,
    output logic                                rvalid,
    output logic [fir_pkg::WORD_W-1:0]          rdata,
    // status events from the datapath
    input  logic                                ss_accept,
    input  logic                                last_done,
    // to the mac engine
    output logic [NUM_TAPS*fir_pkg::WORD_W-1:0] taps,
    output logic                                run,
    output logic                                frame_start
);

    import fir_pkg::*;

    localparam int IDX_W = (NUM_TAPS > 1) ? $clog2(NUM_TAPS) : 1;

    // map constants at bus address width
    localparam logic [ADDR_W-1:0] CTRL_A   = ADDR_W'(CTRL_ADDR);
    localparam logic [ADDR_W-1:0] TAP_LO_A = ADDR_W'(TAP_BASE_ADDR);
    localparam logic [ADDR_W-1:0] TAP_HI_A = ADDR_W'(TAP_BASE_ADDR + 4 * NUM_TAPS);

    // lite FSM encoding
    localparam logic [2:0] S_IDLE    = 3'd0;
    localparam logic [2:0] S_WR_ACK  = 3'd1;
    localparam logic [2:0] S_RD_ADDR = 3'd2;
    localparam logic [2:0] S_RD_DATA = 3'd3;
    localparam logic [2:0] S_RD_WAIT = 3'd4;

    logic [2:0]               state_q;
    logic [2:0]               state_d;
    logic                     wr_fire;
    logic                     rd_fire;
    ctrl_word_u               wr_word;
    ctrl_word_u               rd_d;
    ctrl_word_u               rd_q;
    ctrl_word_u               status_q;
    logic [ADDR_W-1:0]        ra_q;
    logic signed [WORD_W-1:0] coef_q [NUM_TAPS];

    // word aligned and inside the tap window
    function automatic logic is_tap(input logic [ADDR_W-1:0] a);
        return (a >= TAP_LO_A) && (a < TAP_HI_A) && (a[1:0] == 2'b00);
    endfunction

    function automatic logic [IDX_W-1:0] tap_idx(input logic [ADDR_W-1:0] a);
        logic [ADDR_W-1:0] off;
        off = a - TAP_LO_A;
        return off[IDX_W+1:2];
    endfunction

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                // read wins a tie with a write
                if (arvalid) begin
                    state_d = S_RD_ADDR;
                end else if (awvalid && wvalid) begin
                    state_d = S_WR_ACK;
                end
            end
            S_WR_ACK:  state_d = S_IDLE;
            S_RD_ADDR: state_d = S_RD_DATA;
            S_RD_DATA: begin
                if (rready) begin
                    state_d = S_RD_WAIT;
                end
            end
            // one turnaround cycle after a read
            S_RD_WAIT: state_d = S_IDLE;
            default:   state_d = S_IDLE;
        endcase
    end

    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            state_q <= S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // readys straight from the state
    assign awready = (state_q == S_WR_ACK);
    assign wready  = (state_q == S_WR_ACK);
    assign arready = (state_q == S_RD_ADDR);
    assign rvalid  = (state_q == S_RD_DATA);

    // master keeps both valids up until the readys
    assign wr_fire = (state_q == S_WR_ACK);
    assign rd_fire = rvalid && rready;

    // same bits, control or coefficient view by address
    assign wr_word = wdata;

    // read word picked from the incoming address
    always_comb begin
        rd_d = '0;
        if (araddr == CTRL_A) begin
            rd_d.ctrl = status_q.ctrl;
        end else if (is_tap(araddr)) begin
            rd_d.coef = coef_q[tap_idx(araddr)];
        end
    end

    // snapshot on the arready edge, stable while rvalid
    always_ff @(posedge axis_clk) begin
        if (state_q == S_RD_ADDR) begin
            ra_q <= araddr;
            rd_q <= rd_d;
        end
    end

    assign rdata = rd_q;

    // coefficients locked while a frame runs
    always_ff @(posedge axis_clk) begin
        if (wr_fire && is_tap(awaddr) && status_q.ctrl.ap_idle) begin
            coef_q[tap_idx(awaddr)] <= wr_word.coef;
        end
    end

    for (genvar i = 0; i < NUM_TAPS; i++) begin : g_taps
        assign taps[i*WORD_W +: WORD_W] = coef_q[i];
    end

    // ap bits, run and the frame start pulse
    always_ff @(posedge axis_clk or negedge axis_rst_n) begin
        if (!axis_rst_n) begin
            status_q    <= CTRL_RESET;
            run         <= 1'b0;
            frame_start <= 1'b0;
        end else begin
            frame_start <= 1'b0;
            // start only honoured from idle
            if (wr_fire && (awaddr == CTRL_A) && wr_word.ctrl.ap_start &&
                status_q.ctrl.ap_idle) begin
                status_q.ctrl.ap_start <= 1'b1;
                status_q.ctrl.ap_done  <= 1'b0;
                status_q.ctrl.ap_idle  <= 1'b0;
                run                    <= 1'b1;
                frame_start            <= 1'b1;
            end
            // first sample in drops ap_start
            if (ss_accept) begin
                status_q.ctrl.ap_start <= 1'b0;
            end
            // clear on read, only if the word handed out showed done
            if (rd_fire && (ra_q == CTRL_A) && rd_q.ctrl.ap_done) begin
                status_q.ctrl.ap_done <= 1'b0;
            end
            // tlast result left the output stream
            if (last_done) begin
                status_q.ctrl.ap_done <= 1'b1;
                status_q.ctrl.ap_idle <= 1'b1;
                run                   <= 1'b0;
            end
        end
    end

endmodule

// File: src/fir_pkg.sv
package fir_pkg;

    // lite bus word and stream sample width
    localparam int WORD_W = 32;

    // register map, byte addresses
    localparam int CTRL_ADDR     = 'h00;
    // tap i sits at TAP_BASE_ADDR + 4*i
    localparam int TAP_BASE_ADDR = 'h20;

    // idle out of reset, nothing started or done
    localparam logic [WORD_W-1:0] CTRL_RESET = 32'h0000_0004;

    // one lite data word, two readings of it
    typedef union packed {
        // control register layout
        struct packed {
            // upper bits read as zero
            logic [28:0] rsvd;
            // bit 2
            logic        ap_idle;
            // bit 1, cleared when read as set
            logic        ap_done;
            // bit 0, write 1 to start a frame
            logic        ap_start;
        } ctrl;
        // raw coefficient, two's complement
        logic signed [WORD_W-1:0] coef;
    } ctrl_word_u;

endpackage
